/* common/tracker_pkg.sv */
package tracker_pkg;

    // ----------------------------------------------------------
    // Pixel and coordinate widths
    // ----------------------------------------------------------
    localparam int pix_w    = 8;
    localparam int coord_w  = 10;               // Column and line counters
    localparam int sum_s_w  = 20;               // Dark pixel count
    localparam int sum_sx_w = 28;
    localparam int sum_sy_w = 28;

    // ----------------------------------------------------------
    // Report format
    // ----------------------------------------------------------
    localparam logic [7:0] report_header = 8'ha5;
    localparam int report_bytes = 12;
    localparam int report_w     = report_bytes * 8;
    localparam int byte_cnt_w   = $clog2(report_bytes);

    // Field sizes on the wire, each zero-extended
    localparam int sum_s_field_w  = 3 * 8;
    localparam int sum_sx_field_w = 4 * 8;
    localparam int sum_sy_field_w = 4 * 8;

    // UART timing, short for simulation
    localparam int clks_per_bit = 8;
    localparam int bit_cnt_w    = $clog2(clks_per_bit);

    // ----------------------------------------------------------
    // State encodings
    // ----------------------------------------------------------
    typedef enum logic [1:0] {
        grav_st_idle,
        grav_st_accum,
        grav_st_hold
    } grav_state_t;

    typedef enum logic [1:0] {
        fr_st_idle,
        fr_st_load,
        fr_st_wait_tx
    } framer_state_t;

    typedef enum logic [1:0] {
        tx_st_idle,
        tx_st_start,
        tx_st_data,
        tx_st_stop
    } tx_state_t;

endpackage

/* design/camera/cam_input.sv */
`timescale 1ns/10ps

module cam_input (
    input  logic                               cclk,
    input  logic                               rst_n,
    input  logic                               fval,
    input  logic                               lval,
    input  logic                               dval,
    input  logic [tracker_pkg::pix_w-1:0]      pix_data,
    output logic                               pix_valid,
    output logic [tracker_pkg::pix_w-1:0]      pix_value,
    output logic [tracker_pkg::coord_w-1:0]    pix_x,
    output logic [tracker_pkg::coord_w-1:0]    pix_y,
    output logic                               frame_end
);

    logic                               fval_r, lval_r, dval_r;
    logic                               fval_d, lval_d;     // For edge detect
    logic [tracker_pkg::pix_w-1:0]      data_r;
    logic [tracker_pkg::coord_w-1:0]    col_cnt;
    logic [tracker_pkg::coord_w-1:0]    line_cnt;
    logic                               line_seen;          // Line had a valid pixel
    logic                               valid_r;

    assign valid_r = fval_r & lval_r & dval_r;

    // ----------------------------------------------------------
    // Input registers
    // ----------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            fval_r <= 1'b0;
            lval_r <= 1'b0;
            dval_r <= 1'b0;
            fval_d <= 1'b0;
            lval_d <= 1'b0;
        end else begin
            fval_r <= fval;
            lval_r <= lval;
            dval_r <= dval;
            fval_d <= fval_r;
            lval_d <= lval_r;
        end
    end

    always_ff @(posedge cclk) begin
        data_r <= pix_data;
    end

    // Column counts valid pixels only, line counts lines with pixels
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            col_cnt   <= '0;
            line_cnt  <= '0;
            line_seen <= 1'b0;
        end else begin
            if (!lval_r) begin
                col_cnt <= '0;
            end else if (valid_r) begin
                col_cnt <= col_cnt + 1'b1;
            end

            if (frame_end) begin
                line_cnt  <= '0;
                line_seen <= 1'b0;
            end else if (lval_d && !lval_r) begin       // End of line
                if (line_seen) begin
                    line_cnt <= line_cnt + 1'b1;
                end
                line_seen <= 1'b0;
            end else if (valid_r) begin
                line_seen <= 1'b1;
            end
        end
    end

    // ----------------------------------------------------------
    // Output stage
    // ----------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            pix_valid <= 1'b0;
            frame_end <= 1'b0;
        end else begin
            pix_valid <= valid_r;
            frame_end <= fval_d & ~fval_r;  // One cycle after fval_r falls
        end
    end

    always_ff @(posedge cclk) begin
        pix_value <= data_r;
        pix_x     <= col_cnt;
        pix_y     <= line_cnt;
    end

endmodule

/* design/gravity/gravity_acc.sv */
`timescale 1ns/10ps

module gravity_acc (
    input  logic                               cclk,
    input  logic                               rst_n,
    input  logic [tracker_pkg::pix_w-1:0]      threshold,
    input  logic                               pix_valid,
    input  logic [tracker_pkg::pix_w-1:0]      pix_value,
    input  logic [tracker_pkg::coord_w-1:0]    pix_x,
    input  logic [tracker_pkg::coord_w-1:0]    pix_y,
    input  logic                               frame_end,
    input  logic                               report_busy,
    output logic                               result_valid,
    output logic [tracker_pkg::sum_s_w-1:0]    sum_s,
    output logic [tracker_pkg::sum_sx_w-1:0]   sum_sx,
    output logic [tracker_pkg::sum_sy_w-1:0]   sum_sy
);

    tracker_pkg::grav_state_t           state;
    logic [tracker_pkg::sum_s_w-1:0]    acc_s, base_s;
    logic [tracker_pkg::sum_sx_w-1:0]   acc_sx, base_sx;
    logic [tracker_pkg::sum_sy_w-1:0]   acc_sy, base_sy;
    logic                               dark;
    logic                               capture;

    assign dark    = pix_valid && (pix_value < threshold);   // Strictly below
    assign capture = frame_end && (state != tracker_pkg::grav_st_hold);

    // Running sums restart from zero after a frame
    assign base_s  = (state == tracker_pkg::grav_st_hold) ? '0 : acc_s;
    assign base_sx = (state == tracker_pkg::grav_st_hold) ? '0 : acc_sx;
    assign base_sy = (state == tracker_pkg::grav_st_hold) ? '0 : acc_sy;

    // ----------------------------------------------------------
    // Frame FSM
    // ----------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state <= tracker_pkg::grav_st_idle;
        end else begin
            case (state)
                tracker_pkg::grav_st_idle: begin
                    if (frame_end) begin
                        state <= tracker_pkg::grav_st_hold;  // Empty frame
                    end else if (pix_valid) begin
                        state <= tracker_pkg::grav_st_accum;
                    end
                end
                tracker_pkg::grav_st_accum: begin
                    if (frame_end) begin
                        state <= tracker_pkg::grav_st_hold;
                    end
                end
                default: begin
                    state <= tracker_pkg::grav_st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            acc_s  <= '0;
            acc_sx <= '0;
            acc_sy <= '0;
        end else begin
            acc_s  <= base_s + (tracker_pkg::sum_s_w)'(dark);
            acc_sx <= base_sx + (dark ? (tracker_pkg::sum_sx_w)'(pix_x) : '0);
            acc_sy <= base_sy + (dark ? (tracker_pkg::sum_sy_w)'(pix_y) : '0);
        end
    end

    // Result copy, dropped while a report is still going out
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= capture && !report_busy;
        end
    end

    always_ff @(posedge cclk) begin
        if (capture && !report_busy) begin
            sum_s  <= acc_s;
            sum_sx <= acc_sx;
            sum_sy <= acc_sy;
        end
    end

endmodule

/* design/uart/uart_tx.sv */
`timescale 1ns/10ps

module uart_tx (
    input  logic        cclk,
    input  logic        rst_n,
    input  logic        tx_start,
    input  logic [7:0]  tx_data,
    output logic        tx_busy,
    output logic        txd
);

    tracker_pkg::tx_state_t                 state;
    logic [tracker_pkg::bit_cnt_w-1:0]      clk_cnt;        // Cycles within a bit
    logic [2:0]                             bit_idx;
    logic [7:0]                             tx_sr;
    logic                                   bit_end;

    assign bit_end = clk_cnt == (tracker_pkg::bit_cnt_w)'(tracker_pkg::clks_per_bit - 1);
    assign tx_busy = state != tracker_pkg::tx_st_idle;

    // ----------------------------------------------------------
    // 8N1 bit sequencer
    // ----------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state   <= tracker_pkg::tx_st_idle;
            clk_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;                    // Line idles high
        end else begin
            clk_cnt <= (state == tracker_pkg::tx_st_idle || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                tracker_pkg::tx_st_idle: begin
                    if (tx_start) begin
                        state <= tracker_pkg::tx_st_start;
                        txd   <= 1'b0;
                    end
                end
                tracker_pkg::tx_st_start: begin
                    if (bit_end) begin
                        state   <= tracker_pkg::tx_st_data;
                        bit_idx <= '0;
                        txd     <= tx_sr[0];    // LSB first
                    end
                end
                tracker_pkg::tx_st_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= tracker_pkg::tx_st_stop;
                            txd   <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            txd     <= tx_sr[0];
                        end
                    end
                end
                default: begin                  // Stop bit
                    if (bit_end) begin
                        state <= tracker_pkg::tx_st_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge cclk) begin
        if ((state == tracker_pkg::tx_st_idle) && tx_start) begin
            tx_sr <= tx_data;
        end else if (bit_end && (state == tracker_pkg::tx_st_start ||
                                 state == tracker_pkg::tx_st_data)) begin
            tx_sr <= tx_sr >> 1;
        end
    end

endmodule

/* design/uart/report_framer.sv */
`timescale 1ns/10ps

module report_framer (
    input  logic                               cclk,
    input  logic                               rst_n,
    input  logic                               result_valid,
    input  logic [tracker_pkg::sum_s_w-1:0]    sum_s,
    input  logic [tracker_pkg::sum_sx_w-1:0]   sum_sx,
    input  logic [tracker_pkg::sum_sy_w-1:0]   sum_sy,
    input  logic                               tx_busy,
    output logic                               report_busy,
    output logic                               tx_start,
    output logic [7:0]                         tx_data
);

    tracker_pkg::framer_state_t             state;
    logic [tracker_pkg::report_w-1:0]       report_sr;      // MSB byte goes first
    logic [tracker_pkg::byte_cnt_w-1:0]     byte_cnt;
    logic                                   last_byte;

    assign last_byte   = byte_cnt == (tracker_pkg::byte_cnt_w)'(tracker_pkg::report_bytes - 1);
    assign report_busy = state != tracker_pkg::fr_st_idle;
    assign tx_start    = (state == tracker_pkg::fr_st_load) && !tx_busy;
    assign tx_data     = report_sr[tracker_pkg::report_w-1 -: 8];

    // ----------------------------------------------------------
    // Byte sequencer
    // ----------------------------------------------------------
    always_ff @(posedge cclk) begin
        if (!rst_n) begin
            state    <= tracker_pkg::fr_st_idle;
            byte_cnt <= '0;
        end else begin
            case (state)
                tracker_pkg::fr_st_idle: begin
                    byte_cnt <= '0;
                    if (result_valid) begin
                        state <= tracker_pkg::fr_st_load;
                    end
                end
                tracker_pkg::fr_st_load: begin
                    if (!tx_busy) begin
                        state <= tracker_pkg::fr_st_wait_tx;  // Byte handed over
                    end
                end
                tracker_pkg::fr_st_wait_tx: begin
                    if (!tx_busy) begin                       // Stop bit done
                        if (last_byte) begin
                            state <= tracker_pkg::fr_st_idle;
                        end else begin
                            byte_cnt <= byte_cnt + 1'b1;
                            state    <= tracker_pkg::fr_st_load;
                        end
                    end
                end
                default: begin
                    state <= tracker_pkg::fr_st_idle;
                end
            endcase
        end
    end

    // Report image: header, then count, x sum and y sum
    always_ff @(posedge cclk) begin
        if ((state == tracker_pkg::fr_st_idle) && result_valid) begin
            report_sr <= {tracker_pkg::report_header,
                          (tracker_pkg::sum_s_field_w)'(sum_s),
                          (tracker_pkg::sum_sx_field_w)'(sum_sx),
                          (tracker_pkg::sum_sy_field_w)'(sum_sy)};
        end else if (tx_start) begin
            report_sr <= report_sr << 8;
        end
    end

endmodule

/* design/tracker_top.sv */
`timescale 1ns/10ps

module tracker_top (
    input  logic                               cclk,
    input  logic                               rst_n,
    input  logic                               fval,
    input  logic                               lval,
    input  logic                               dval,
    input  logic [tracker_pkg::pix_w-1:0]      pix_data,
    input  logic [tracker_pkg::pix_w-1:0]      threshold,
    output logic                               uart_txd
);

    // ----------------------------------------------------------
    // Camera to accumulator
    // ----------------------------------------------------------
    logic                               pix_valid;
    logic [tracker_pkg::pix_w-1:0]      pix_value;
    logic [tracker_pkg::coord_w-1:0]    pix_x;
    logic [tracker_pkg::coord_w-1:0]    pix_y;
    logic                               frame_end;

    // Accumulator to framer
    logic                               result_valid;
    logic [tracker_pkg::sum_s_w-1:0]    sum_s;
    logic [tracker_pkg::sum_sx_w-1:0]   sum_sx;
    logic [tracker_pkg::sum_sy_w-1:0]   sum_sy;
    logic                               report_busy;

    // Framer to UART
    logic                               tx_start;
    logic [7:0]                         tx_data;
    logic                               tx_busy;

    cam_input u_cam_input (
        .cclk(cclk), .rst_n(rst_n),
        .fval(fval), .lval(lval), .dval(dval), .pix_data(pix_data),
        .pix_valid(pix_valid), .pix_value(pix_value),
        .pix_x(pix_x), .pix_y(pix_y), .frame_end(frame_end)
    );

    gravity_acc u_gravity_acc (
        .cclk(cclk), .rst_n(rst_n), .threshold(threshold),
        .pix_valid(pix_valid), .pix_value(pix_value),
        .pix_x(pix_x), .pix_y(pix_y), .frame_end(frame_end),
        .report_busy(report_busy), .result_valid(result_valid),
        .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy)
    );

    report_framer u_report_framer (
        .cclk(cclk), .rst_n(rst_n), .result_valid(result_valid),
        .sum_s(sum_s), .sum_sx(sum_sx), .sum_sy(sum_sy),
        .tx_busy(tx_busy), .report_busy(report_busy),
        .tx_start(tx_start), .tx_data(tx_data)
    );

    uart_tx u_uart_tx (
        .cclk(cclk), .rst_n(rst_n),
        .tx_start(tx_start), .tx_data(tx_data),
        .tx_busy(tx_busy), .txd(uart_txd)       // Serial report out
    );

endmodule

/* sim/tb_tracker.sv */
`timescale 1ns/10ps

module tb_tracker;

    // Report format and bit timing of the serial link
    localparam logic [7:0] header_byte = 8'ha5;
    localparam int         report_len  = 12;
    localparam int         bit_clks    = 8;

    logic       cclk;
    logic       rst_n;
    logic       fval, lval, dval;
    logic [7:0] pix_data;
    logic [7:0] threshold;
    logic       uart_txd;

    // Frame table from the pattern file
    int f_thr[64], f_w[64], f_h[64], f_x0[64], f_y0[64], f_rw[64], f_rh[64];
    int f_rv[64], f_bg[64], f_follow[64], f_s[64], f_sx[64], f_sy[64];
    int nf = 0;

    logic [31:0] exp_s_q[$];
    logic [31:0] exp_sx_q[$];
    logic [31:0] exp_sy_q[$];
    logic [7:0]  rep[0:report_len-1];       // Bytes of the report being received
    int          byte_idx = 0;
    int          hdr_frames = 0;            // Frames ended at the last header
    int          frames_done = 0;
    int          reports_got = 0;
    int          reports_expected = 0;
    int          value_errors = 0;
    int          other_errors = 0;
    int          limit = 100;
    int          cycles = 0;
    bit          limit_ready = 1'b0;

    tracker_top dut (
        .cclk(cclk), .rst_n(rst_n), .fval(fval), .lval(lval), .dval(dval),
        .pix_data(pix_data), .threshold(threshold), .uart_txd(uart_txd)
    );

    initial begin
        cclk = 1'b0;
        forever #2 cclk = ~cclk;
    end

    // ----------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------
    task automatic next_cycle();
        @(posedge cclk);
        #1;
    endtask

    function automatic logic [7:0] pixel_at(input int f, input int x, input int y);
        bit inside_rect;
        inside_rect = x >= f_x0[f] && x < f_x0[f] + f_rw[f] &&
                      y >= f_y0[f] && y < f_y0[f] + f_rh[f];
        return inside_rect ? 8'(f_rv[f]) : 8'(f_bg[f]);
    endfunction

    // Dark means strictly below threshold, coordinates count from 0
    task automatic rule_sums(input int f, output int s, output int sx, output int sy);
        int x, y;
        s = 0;
        sx = 0;
        sy = 0;
        for (y = 0; y < f_h[f]; y++) begin
            for (x = 0; x < f_w[f]; x++) begin
                if (int'(pixel_at(f, x, y)) < f_thr[f]) begin
                    s++;
                    sx += x;
                    sy += y;
                end
            end
        end
    endtask

    task automatic drive_frame(input int f);
        int x, y, gap;
        threshold = 8'(f_thr[f]);
        fval = 1'b1;
        repeat (2) next_cycle();
        for (y = 0; y < f_h[f]; y++) begin
            lval = 1'b1;
            for (x = 0; x < f_w[f]; x++) begin
                if ($urandom % 4 == 0) begin    // Idle dval cycle with junk data
                    dval = 1'b0;
                    pix_data = 8'($urandom);
                    next_cycle();
                end
                dval = 1'b1;
                pix_data = pixel_at(f, x, y);
                next_cycle();
            end
            dval = 1'b0;
            lval = 1'b0;
            gap = 2 + $urandom % 3;
            repeat (gap) next_cycle();
        end
        fval = 1'b0;
        frames_done++;
        repeat (4) next_cycle();
    endtask

    task automatic compare_field(input string name, input logic [31:0] exp,
                                 input logic [31:0] got);
        if (got !== exp) begin
            value_errors++;
            $display("FAIL t=%0t %s expected %0d got %0d", $time, name, exp, got);
        end
    endtask

    task automatic check_report();
        logic [31:0] got_s, got_sx, got_sy;
        got_s  = {8'h00, rep[1], rep[2], rep[3]};   // MSB first on the wire
        got_sx = {rep[4], rep[5], rep[6], rep[7]};
        got_sy = {rep[8], rep[9], rep[10], rep[11]};
        reports_got++;
        if (rep[0] !== header_byte) begin
            value_errors++;
            $display("FAIL t=%0t header expected %h got %h", $time, header_byte, rep[0]);
        end
        if (exp_s_q.size() == 0) begin
            other_errors++;
            $display("A report arrived at %0t although no frame was waiting for one", $time);
        end else begin
            compare_field("sum_s", exp_s_q.pop_front(), got_s);
            compare_field("sum_sx", exp_sx_q.pop_front(), got_sx);
            compare_field("sum_sy", exp_sy_q.pop_front(), got_sy);
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d wrong values, %0d other failures, %0d of %0d reports received",
                 value_errors, other_errors, reports_got, reports_expected);
    endtask

    // ----------------------------------------------------------
    // UART decoder sampling mid-bit on the falling clock edge
    // ----------------------------------------------------------
    initial begin : uart_monitor
        logic [7:0] rx;
        bit         idle_bad;
        int         i;
        idle_bad = 1'b0;
        @(negedge cclk);
        forever begin
            while (uart_txd !== 1'b0) begin
                if (uart_txd !== 1'b1 && !idle_bad) begin
                    idle_bad = 1'b1;
                    other_errors++;
                    $display("uart_txd is not high on an idle line at %0t", $time);
                end
                @(negedge cclk);
            end
            if (frames_done == 0) begin
                other_errors++;
                $display("uart_txd left idle before the first frame ended, at %0t", $time);
            end
            repeat (bit_clks / 2) @(negedge cclk);
            if (uart_txd !== 1'b0) begin
                other_errors++;
                $display("Start bit ended early at %0t", $time);
            end
            for (i = 0; i < 8; i++) begin
                repeat (bit_clks) @(negedge cclk);
                rx[i] = uart_txd;                   // LSB first
            end
            repeat (bit_clks) @(negedge cclk);
            if (uart_txd !== 1'b1) begin
                other_errors++;
                $display("Stop bit missing at %0t", $time);
            end
            if (byte_idx == 0) begin
                if (frames_done <= hdr_frames) begin
                    other_errors++;
                    $display("A report started at %0t with no new frame ended", $time);
                end
                hdr_frames = frames_done;
            end
            rep[byte_idx] = rx;
            byte_idx++;
            if (byte_idx == report_len) begin
                check_report();
                byte_idx = 0;
            end
        end
    end

    initial begin : watchdog
        wait (limit_ready);
        while (cycles < limit) begin
            @(posedge cclk);
            cycles++;
        end
        $display("Timeout after %0d cycles, the DUT stopped sending reports", cycles);
        print_counts();
        $display("Result: FAILED");
        $finish;
    end

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin : main_flow
        int    fd, rc, n, line_no, f, s, sx, sy, seed;
        string line;
        seed = $urandom(65229);
        rst_n = 1'b0;
        fval = 1'b0;
        lval = 1'b0;
        dval = 1'b0;
        pix_data = 8'h00;
        threshold = 8'h00;
        line_no = 0;
        fd = $fopen("sim/frame_patterns.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("Cannot open sim/frame_patterns.txt");
        end else begin
            while (!$feof(fd) && nf < 64) begin
                line = "";
                rc = $fgets(line, fd);
                line_no++;
                if (rc > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d",
                                f_thr[nf], f_w[nf], f_h[nf], f_x0[nf], f_y0[nf],
                                f_rw[nf], f_rh[nf], f_rv[nf], f_bg[nf], f_follow[nf],
                                f_s[nf], f_sx[nf], f_sy[nf]);
                    if (n != 13) begin
                        other_errors++;
                        $display("Pattern line %0d cannot be parsed", line_no);
                    end else begin
                        rule_sums(nf, s, sx, sy);
                        if (s != f_s[nf] || sx != f_sx[nf] || sy != f_sy[nf]) begin
                            other_errors++;
                            $display(
                                "Pattern line %0d disagrees with the rectangle rule (%0d %0d %0d)",
                                line_no, s, sx, sy);
                        end
                        limit += (f_w[nf] + 4) * (f_h[nf] + 2) * 2;
                        if (f_follow[nf] == 0) begin
                            limit += 1200;
                        end
                        nf++;
                    end
                end
            end
            $fclose(fd);
        end
        limit_ready = 1'b1;

        repeat (16) next_cycle();
        rst_n = 1'b1;

        for (f = 0; f < nf; f++) begin
            if (f_follow[f] == 0) begin         // Idle gap until the report path is free
                while (reports_got < reports_expected) next_cycle();
                repeat (20) next_cycle();
                exp_s_q.push_back(f_s[f]);
                exp_sx_q.push_back(f_sx[f]);
                exp_sy_q.push_back(f_sy[f]);
                reports_expected++;
            end
            drive_frame(f);
        end
        while (reports_got < reports_expected) next_cycle();
        repeat (200) next_cycle();              // Catch any stray bytes
        if (byte_idx != 0) begin
            other_errors++;
            $display("Last report stopped after %0d bytes", byte_idx);
        end
        print_counts();
        if (value_errors + other_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

/* sim/frame_patterns.txt */
# thr width height x0 y0 rect_w rect_h rect_val bg_val follow exp_s exp_sx exp_sy
# Decimal values, follow=1 starts the frame right after the previous one
100 16 12 4 3 5 4 20 200 0 20 120 90
50 8 6 0 0 8 6 60 90 0 0 0 0
70 8 6 2 1 3 2 60 90 0 6 18 9
255 10 4 0 0 1 1 255 0 0 39 180 60
100 6 4 1 1 2 2 10 200 1 4 6 6
40 20 10 10 5 6 3 39 40 0 18 225 108
128 32 16 20 8 10 6 0 255 0 60 1470 630
10 12 8 8 5 4 3 9 10 0 12 114 72
200 64 40 0 0 1 1 250 100 0 2559 80640 49920
1 16 8 3 2 4 4 0 1 0 16 72 56
128 5 3 0 0 5 3 0 0 1 15 30 15
128 4 4 1 1 1 1 127 128 0 1 1 1

/* build.f */
common/tracker_pkg.sv
design/camera/cam_input.sv
design/gravity/gravity_acc.sv
design/uart/uart_tx.sv
design/uart/report_framer.sv
design/tracker_top.sv
sim/tb_tracker.sv

/* Makefile */
# Verilator build and run for the eye-tracking front end

VERILATOR ?= verilator
TOP       ?= tb_tracker
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "Result: PASSED"

clean:
	rm -rf $(OBJ_DIR)
